// File: include/usb_ctrl_settings.svh
`ifndef USB_CTRL_SETTINGS_SVH
`define USB_CTRL_SETTINGS_SVH

// device identity
`define USB_VENDOR_ID       16'h1D50
`define USB_PRODUCT_ID      16'h6130

// max packet sizes, full speed
`define USB_CTRL_MPS        8   // endpoint 0
`define USB_BULK_MPS        8   // data interface, both directions

// descriptor sizes in bytes
`define USB_DEV_DESCR_LEN   18
`define USB_CONF_DESCR_LEN  67  // config + cdc interfaces + endpoints

// byte counter must reach the longest reply
`define USB_BC_WIDTH        7

// interrupt endpoint of the comm interface
`define USB_INT_MPS         8
`define USB_INT_INTERVAL    255 // ms

`endif

// File: hdl/usb_ctrl_pkg.sv
`default_nettype none
`include "usb_ctrl_settings.svh"

package usb_ctrl_pkg;

  typedef enum logic [2:0] {
    ST_IDLE, ST_STALL, ST_SETUP, ST_IN_DATA, ST_OUT_DATA,
    ST_PRE_IN_STATUS, ST_IN_STATUS, ST_OUT_STATUS
  } ctrl_state_e;

  typedef enum logic [1:0] {DEV_POWERED, DEV_DEFAULT, DEV_ADDRESS, DEV_CONFIGURED} dev_state_e;

  typedef enum logic [2:0] {
    REQ_NONE, REQ_GET_STATUS, REQ_SET_ADDRESS, REQ_GET_DESCR_DEV,
    REQ_GET_DESCR_CONF, REQ_GET_CONFIG, REQ_SET_CONFIG, REQ_UNSUPPORTED
  } req_kind_e;

  // wValue as SET_ADDRESS / SET_CONFIGURATION see it
  typedef struct packed {
    logic [7:0] rsvd;  // must be zero
    logic       zero;  // address > 127 if set
    logic [6:0] addr;
  } addr_view_t;

  // wValue as GET_DESCRIPTOR sees it
  typedef struct packed {
    logic [7:0] dtype;
    logic [7:0] index;
  } descr_view_t;

  typedef union packed {
    addr_view_t  addr;
    descr_view_t descr;
  } setup_value_u;

  typedef struct packed {
    logic                     in_dir;  // device to host
    req_kind_e                kind;
    setup_value_u             value;
    logic [`USB_BC_WIDTH-1:0] length;  // wLength, saturated
  } setup_req_t;

  typedef struct packed {
    logic [7:0] data;
    logic valid;
    logic err;
    logic setup;
    logic ready;
  } sie_out_t;

  typedef struct packed {
    logic req;
    logic ready;
    logic data_ack;
  } sie_in_t;

  typedef struct packed {
    logic [7:0] data;
    logic zlp;
    logic valid;
  } in_byte_t;

endpackage

`default_nettype wire

// File: hdl/setup_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "usb_ctrl_settings.svh"

module setup_decoder import usb_ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rstn,
  input  logic        clk_gate_i,
  input  logic        bus_reset_i,
  input  sie_out_t    sie_out_i,
  input  ctrl_state_e stage_i,
  input  dev_state_e  dev_state_i,
  output setup_req_t  req_o,
  output logic        byte_ok_o
);

  localparam logic [7:0] GET_STATUS = 8'h00;  // standard bRequest codes
  localparam logic [7:0] SET_ADDRESS = 8'h05;
  localparam logic [7:0] GET_DESCRIPTOR = 8'h06;
  localparam logic [7:0] GET_CONFIGURATION = 8'h08;
  localparam logic [7:0] SET_CONFIGURATION = 8'h09;

  logic [3:0]               cnt_q;  // 9 = too many bytes
  logic [7:0]               bm_type_q, b_req_q;
  setup_value_u             w_value_q;
  logic [15:0]              w_index_q, w_length_q;
  logic                     std_ok, rec_dev, in_dir, addr_ok;
  logic [7:0]               cfg_val;
  logic [`USB_BC_WIDTH-1:0] len_sat;
  req_kind_e                kind;

  always_ff @(posedge clk_i or negedge rstn) begin
    if (!rstn) begin
      cnt_q <= '0;
    end else if (clk_gate_i) begin
      if (bus_reset_i || (sie_out_i.ready && sie_out_i.setup)) begin
        cnt_q <= '0;  // fresh setup token
      end else if (sie_out_i.ready && sie_out_i.valid && stage_i == ST_SETUP) begin
        if (cnt_q != 4'd9) cnt_q <= cnt_q + 4'd1;
      end
    end
  end

  // setup payload, written in arrival order
  always_ff @(posedge clk_i) begin
    if (clk_gate_i && sie_out_i.ready && sie_out_i.valid && stage_i == ST_SETUP) begin
      case (cnt_q)
        4'd0: bm_type_q <= sie_out_i.data;
        4'd1: b_req_q <= sie_out_i.data;
        4'd2: w_value_q.descr.index <= sie_out_i.data;  // low byte, also the address
        4'd3: w_value_q.descr.dtype <= sie_out_i.data;
        4'd4: w_index_q[7:0] <= sie_out_i.data;
        4'd5: w_index_q[15:8] <= sie_out_i.data;
        4'd6: w_length_q[7:0] <= sie_out_i.data;
        4'd7: w_length_q[15:8] <= sie_out_i.data;
        default: begin
        end
      endcase
    end
  end

  assign byte_ok_o = cnt_q == 4'd8;
  assign std_ok = bm_type_q[6:2] == 5'd0 && bm_type_q[1:0] != 2'b11;  // standard, no rsvd bits
  assign rec_dev = bm_type_q[1:0] == 2'b00;
  assign in_dir = bm_type_q[7];
  assign addr_ok = dev_state_i inside {DEV_ADDRESS, DEV_CONFIGURED};
  assign cfg_val = {w_value_q.addr.zero, w_value_q.addr.addr};  // config value in low byte
  assign len_sat = (w_length_q[15:`USB_BC_WIDTH] != '0) ? '1 : w_length_q[`USB_BC_WIDTH-1:0];

  always_comb begin
    kind = REQ_UNSUPPORTED;
    if (std_ok && w_index_q == 16'd0) begin
      case (b_req_q)
        GET_STATUS:
          if (in_dir && w_value_q == '0 && w_length_q == 16'd2 && addr_ok) kind = REQ_GET_STATUS;
        SET_ADDRESS:
          if (!in_dir && rec_dev && w_value_q.addr.rsvd == 8'd0 && !w_value_q.addr.zero &&
              w_length_q == 16'd0) kind = REQ_SET_ADDRESS;
        GET_DESCRIPTOR:
          if (in_dir && rec_dev && w_value_q.descr.index == 8'd0) begin
            if (w_value_q.descr.dtype == 8'd1) kind = REQ_GET_DESCR_DEV;
            else if (w_value_q.descr.dtype == 8'd2) kind = REQ_GET_DESCR_CONF;
          end
        GET_CONFIGURATION:
          if (in_dir && rec_dev && w_value_q == '0 && w_length_q == 16'd1 && addr_ok)
            kind = REQ_GET_CONFIG;
        SET_CONFIGURATION:
          if (!in_dir && rec_dev && w_value_q.addr.rsvd == 8'd0 && cfg_val <= 8'd1 &&
              w_length_q == 16'd0 && addr_ok) kind = REQ_SET_CONFIG;
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    req_o = '0;  // kind none until a complete setup is held
    if (byte_ok_o) begin
      req_o.in_dir = in_dir;
      req_o.kind = kind;
      req_o.value = w_value_q;
      req_o.length = len_sat;
    end
  end

endmodule

`default_nettype wire

// File: hdl/ctrl_stage_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "usb_ctrl_settings.svh"

module ctrl_stage_fsm import usb_ctrl_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rstn,
  input  logic                     clk_gate_i,
  input  logic                     bus_reset_i,
  input  sie_out_t                 sie_out_i,
  input  sie_in_t                  sie_in_i,
  input  setup_req_t               req_i,
  input  logic                     byte_ok_i,
  input  logic                     in_last_i,
  output ctrl_state_e              stage_o,
  output logic [`USB_BC_WIDTH-1:0] byte_cnt_o,
  output logic                     status_ack_o,
  output logic                     stall_o
);

  ctrl_state_e              stage_q, stage_d;
  logic [`USB_BC_WIDTH-1:0] cnt_q, cnt_d;
  logic                     strobe, proto_err, done;

  assign strobe = clk_gate_i & (sie_in_i.ready | sie_out_i.ready);

  // tokens the host must not send in this stage
  always_comb begin
    proto_err = 1'b0;
    if (sie_in_i.ready) begin
      case (stage_q)
        ST_SETUP: proto_err = 1'b1;
        ST_OUT_DATA, ST_PRE_IN_STATUS: proto_err = !sie_in_i.req;
        ST_IN_STATUS: proto_err = !sie_in_i.data_ack;  // only the ack of our zlp
        ST_OUT_STATUS: proto_err = !sie_in_i.req && !sie_in_i.data_ack;
        default: begin
        end
      endcase
    end
    if (sie_out_i.ready) begin
      case (stage_q)
        ST_IN_DATA, ST_PRE_IN_STATUS, ST_IN_STATUS: proto_err = 1'b1;
        ST_OUT_STATUS: if (sie_out_i.valid) proto_err = 1'b1;  // status must be empty
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    stage_d = stage_q;
    cnt_d = '0;  // counter only lives in the data stage
    done = 1'b0;
    if (sie_out_i.ready && sie_out_i.err) begin
      if (stage_q != ST_STALL) stage_d = ST_IDLE;
    end else if (sie_out_i.ready && sie_out_i.setup) begin
      stage_d = ST_SETUP;  // clears stall too
    end else if (proto_err) begin
      stage_d = ST_STALL;
    end else begin
      case (stage_q)
        ST_SETUP:
          if (sie_out_i.ready && !sie_out_i.valid) begin  // eop of setup packet
            if (!byte_ok_i || req_i.kind == REQ_UNSUPPORTED) stage_d = ST_STALL;
            else if (req_i.in_dir) stage_d = ST_IN_DATA;
            else if (req_i.length == '0) stage_d = ST_PRE_IN_STATUS;
            else stage_d = ST_OUT_DATA;
          end
        ST_IN_DATA: begin
          cnt_d = cnt_q;
          if (in_last_i) begin
            if (sie_in_i.data_ack) stage_d = ST_OUT_STATUS;
            else if (!sie_in_i.req) stage_d = ST_STALL;  // byte wanted, none left
          end else if (!sie_in_i.req && !sie_in_i.data_ack) begin
            cnt_d = cnt_q + 1'b1;  // byte taken
          end
        end
        ST_OUT_DATA, ST_PRE_IN_STATUS: if (sie_in_i.ready) stage_d = ST_IN_STATUS;
        ST_IN_STATUS:
          if (sie_in_i.ready) begin
            stage_d = ST_IDLE;
            done = 1'b1;
          end
        ST_OUT_STATUS: if (sie_out_i.ready) stage_d = ST_IDLE;  // empty out packet ended
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rstn) begin
    if (!rstn) begin
      stage_q <= ST_IDLE;
      cnt_q <= '0;
    end else if (clk_gate_i) begin
      if (bus_reset_i) begin
        stage_q <= ST_IDLE;
        cnt_q <= '0;
      end else if (strobe) begin
        stage_q <= stage_d;
        cnt_q <= cnt_d;
      end
    end
  end

  assign stage_o = stage_q;
  assign byte_cnt_o = cnt_q;
  assign stall_o = stage_q == ST_STALL;
  assign status_ack_o = strobe & ~bus_reset_i & done;

endmodule

`default_nettype wire

// File: hdl/descr_in_source.sv
`timescale 1ns/1ps
`default_nettype none
`include "usb_ctrl_settings.svh"

module descr_in_source import usb_ctrl_pkg::*; (
  input  ctrl_state_e              stage_i,
  input  logic [`USB_BC_WIDTH-1:0] byte_cnt_i,
  input  setup_req_t               req_i,
  input  dev_state_e               dev_state_i,
  output in_byte_t                 in_byte_o,
  output logic                     in_last_o
);

  localparam logic [15:0] VID = `USB_VENDOR_ID;
  localparam logic [15:0] PID = `USB_PRODUCT_ID;
  localparam logic [15:0] CONF_LEN = 16'(`USB_CONF_DESCR_LEN);
  localparam logic [7:0]  DEV_LEN = 8'(`USB_DEV_DESCR_LEN);
  localparam logic [7:0]  CTRL_MPS = 8'(`USB_CTRL_MPS);
  localparam logic [7:0]  BULK_MPS = 8'(`USB_BULK_MPS);
  localparam logic [7:0]  INT_MPS = 8'(`USB_INT_MPS);
  localparam logic [7:0]  INT_IVAL = 8'(`USB_INT_INTERVAL);
  localparam int          DEV_AW = $clog2(`USB_DEV_DESCR_LEN);
  localparam int          CONF_AW = $clog2(`USB_CONF_DESCR_LEN);

  // class 02, usb 2.00, bcdDevice 1.10, no strings, one config
  localparam logic [7:0] DEV_DESCR [`USB_DEV_DESCR_LEN] = '{
    DEV_LEN, 8'h01, 8'h00, 8'h02, 8'h02, 8'h00, 8'h00, CTRL_MPS,
    VID[7:0], VID[15:8], PID[7:0], PID[15:8], 8'h10, 8'h01, 8'h00, 8'h00, 8'h00, 8'h01
  };

  localparam logic [7:0] CONF_DESCR [`USB_CONF_DESCR_LEN] = '{
    8'h09, 8'h02, CONF_LEN[7:0], CONF_LEN[15:8], 8'h02, 8'h01, 8'h00, 8'h80, 8'h32,  // config
    8'h09, 8'h04, 8'h00, 8'h00, 8'h01, 8'h02, 8'h02, 8'h01, 8'h00,  // comm iface, acm
    8'h05, 8'h24, 8'h00, 8'h10, 8'h01,         // cdc header 1.10
    8'h05, 8'h24, 8'h01, 8'h00, 8'h01,         // call management
    8'h04, 8'h24, 8'h02, 8'h00,                // acm functional
    8'h05, 8'h24, 8'h06, 8'h00, 8'h01,         // union, master 0 slave 1
    8'h07, 8'h05, 8'h82, 8'h03, INT_MPS, 8'h00, INT_IVAL,  // ep2 in, interrupt
    8'h09, 8'h04, 8'h01, 8'h00, 8'h02, 8'h0A, 8'h00, 8'h00, 8'h00,  // data iface
    8'h07, 8'h05, 8'h01, 8'h02, BULK_MPS, 8'h00, 8'h00,  // ep1 out, bulk
    8'h07, 8'h05, 8'h81, 8'h02, BULK_MPS, 8'h00, 8'h00   // ep1 in, bulk
  };

  logic [`USB_BC_WIDTH-1:0] reply_len, limit;
  logic [7:0]               reply_data;

  always_comb begin
    reply_len = '0;
    reply_data = 8'h00;  // get_status: bus powered, no wakeup
    case (req_i.kind)
      REQ_GET_DESCR_DEV: begin
        reply_len = `USB_BC_WIDTH'(`USB_DEV_DESCR_LEN);
        reply_data = DEV_DESCR[byte_cnt_i[DEV_AW-1:0]];
      end
      REQ_GET_DESCR_CONF: begin
        reply_len = `USB_BC_WIDTH'(`USB_CONF_DESCR_LEN);
        reply_data = CONF_DESCR[byte_cnt_i[CONF_AW-1:0]];
      end
      REQ_GET_CONFIG: begin
        reply_len = `USB_BC_WIDTH'(1);
        reply_data = {7'd0, dev_state_i == DEV_CONFIGURED};
      end
      REQ_GET_STATUS: reply_len = `USB_BC_WIDTH'(2);
      default: begin
      end
    endcase
  end

  assign limit = (req_i.length < reply_len) ? req_i.length : reply_len;  // short host read
  assign in_last_o = byte_cnt_i >= limit;

  always_comb begin
    in_byte_o = '0;
    if (stage_i == ST_IN_DATA && !in_last_o) begin
      in_byte_o.valid = 1'b1;
      in_byte_o.data = reply_data;
    end else if (stage_i == ST_IN_STATUS) begin
      in_byte_o.valid = 1'b1;  // empty status packet
      in_byte_o.zlp = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/device_state.sv
`timescale 1ns/1ps
`default_nettype none

module device_state import usb_ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rstn,
  input  logic       clk_gate_i,
  input  logic       bus_reset_i,
  input  setup_req_t req_i,
  input  logic       status_ack_i,
  output dev_state_e dev_state_o,
  output logic [6:0] addr_o,
  output logic       usb_en_o,
  output logic       configured_o
);

  dev_state_e state_q;
  logic [6:0] addr_q;  // committed address, sie matches tokens on it

  always_ff @(posedge clk_i or negedge rstn) begin
    if (!rstn) begin
      state_q <= DEV_POWERED;  // until the first bus reset
      addr_q <= 7'd0;
    end else if (clk_gate_i) begin
      if (bus_reset_i) begin
        state_q <= DEV_DEFAULT;
        addr_q <= 7'd0;
      end else if (status_ack_i) begin
        // requests commit only after their status stage
        case (req_i.kind)
          REQ_SET_ADDRESS: begin
            addr_q <= req_i.value.addr.addr;
            state_q <= (req_i.value.addr.addr == 7'd0) ? DEV_DEFAULT : DEV_ADDRESS;
          end
          REQ_SET_CONFIG: state_q <= req_i.value.addr.addr[0] ? DEV_CONFIGURED : DEV_ADDRESS;
          default: begin
          end
        endcase
      end
    end
  end

  assign dev_state_o = state_q;
  assign addr_o = addr_q;
  assign usb_en_o = state_q != DEV_POWERED;  // pull-up enable
  assign configured_o = state_q == DEV_CONFIGURED;

endmodule

`default_nettype wire

// File: hdl/usb_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "usb_ctrl_settings.svh"

// endpoint 0 of a single port cdc-acm device
module usb_ctrl_top import usb_ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rstn,
  input  logic       clk_gate_i,    // one clk_i per bit time
  input  logic       bus_reset_i,
  input  sie_out_t   sie_out_i,
  input  sie_in_t    sie_in_i,
  output in_byte_t   in_byte_o,
  output logic       stall_o,
  output logic       usb_en_o,
  output logic       configured_o,
  output logic [6:0] addr_o
);

  setup_req_t               req;
  ctrl_state_e              stage;
  dev_state_e               dev_state;
  logic [`USB_BC_WIDTH-1:0] byte_cnt;
  logic                     byte_ok;     // exactly 8 setup bytes seen
  logic                     in_last;     // reply exhausted
  logic                     status_ack;  // zlp of status stage taken

  setup_decoder u_setup_decoder (
    .clk_i, .rstn, .clk_gate_i, .bus_reset_i, .sie_out_i,
    .stage_i(stage), .dev_state_i(dev_state), .req_o(req), .byte_ok_o(byte_ok)
  );

  ctrl_stage_fsm u_ctrl_stage_fsm (
    .clk_i, .rstn, .clk_gate_i, .bus_reset_i, .sie_out_i, .sie_in_i,
    .req_i(req), .byte_ok_i(byte_ok), .in_last_i(in_last),
    .stage_o(stage), .byte_cnt_o(byte_cnt), .status_ack_o(status_ack), .stall_o
  );

  descr_in_source u_descr_in_source (
    .stage_i(stage), .byte_cnt_i(byte_cnt), .req_i(req), .dev_state_i(dev_state),
    .in_byte_o, .in_last_o(in_last)
  );

  device_state u_device_state (
    .clk_i, .rstn, .clk_gate_i, .bus_reset_i, .req_i(req), .status_ack_i(status_ack),
    .dev_state_o(dev_state), .addr_o, .usb_en_o, .configured_o
  );

endmodule

`default_nettype wire

// File: test/usb_ctrl_properties.sv
`timescale 1ns/1ps
`default_nettype none

module usb_ctrl_properties import usb_ctrl_pkg::*; (
  input logic       clk_i,
  input logic       rstn,
  input logic       clk_gate_i,
  input in_byte_t   in_byte_o,
  input logic       stall_o,
  input logic [6:0] addr_o
);

  int fail_cnt = 0;

  zlp_has_valid: assert property (@(posedge clk_i) disable iff (!rstn)
    in_byte_o.zlp |-> in_byte_o.valid)
    else begin
      fail_cnt++;
      $error("zlp high without in valid");
    end

  no_data_when_stalled: assert property (@(posedge clk_i) disable iff (!rstn)
    !(stall_o && in_byte_o.valid))
    else begin
      fail_cnt++;
      $error("stall and in valid both high");
    end

  // address register only moves on a bit-time clock
  addr_only_on_gate: assert property (@(posedge clk_i) disable iff (!rstn)
    !$past(clk_gate_i) |-> $stable(addr_o))
    else begin
      fail_cnt++;
      $error("addr_o changed without clk_gate_i");
    end

endmodule

bind usb_ctrl_top usb_ctrl_properties u_usb_ctrl_properties (
  .clk_i, .rstn, .clk_gate_i, .in_byte_o, .stall_o, .addr_o
);

`default_nettype wire

// File: test/tb_usb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "usb_ctrl_settings.svh"

module tb_usb_ctrl import usb_ctrl_pkg::*; ();

  localparam int VEC_WORDS = 13;  // 8 setup bytes, outcome, count, sum, addr, configured
  localparam int MAX_VECS = 32;
  localparam int GATE_WAIT = 12;  // clocks allowed to find a gated edge
  localparam int MAX_BYTES = 100;

  logic        clk_i = 1'b0;
  logic        rstn, clk_gate_i, bus_reset_i;
  logic [1:0]  gate_cnt;
  sie_out_t    sie_out;
  sie_in_t     sie_in;
  in_byte_t    in_byte;
  logic        stall, usb_en, configured;
  logic [6:0]  addr;
  logic [15:0] vec_mem [VEC_WORDS*MAX_VECS+1];  // word 0 holds the vector count
  logic [31:0] lcg_state;
  int          errors = 0;
  int          tests = 0;
  int          failed = 0;

  always #5 clk_i = ~clk_i;

  // bit-time enable, one clock in four
  always @(posedge clk_i) begin
    #1;
    gate_cnt = gate_cnt + 2'd1;
    clk_gate_i = gate_cnt == 2'd0;
  end

  usb_ctrl_top u_usb_ctrl_top (
    .clk_i, .rstn, .clk_gate_i, .bus_reset_i,
    .sie_out_i(sie_out), .sie_in_i(sie_in), .in_byte_o(in_byte),
    .stall_o(stall), .usb_en_o(usb_en), .configured_o(configured), .addr_o(addr)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic sie_out_t out_tok(input logic [7:0] data, input logic valid,
                                       input logic setup);
    sie_out_t t;
    t = '0;
    t.data = data;
    t.valid = valid;
    t.setup = setup;
    t.ready = 1'b1;
    return t;
  endfunction

  function automatic sie_in_t in_tok(input logic req, input logic ack);
    sie_in_t t;
    t = '0;
    t.req = req;
    t.ready = 1'b1;
    t.data_ack = ack;
    return t;
  endfunction

  function automatic string outcome_name(input int code);
    case (code)
      1: return "read";
      2: return "no-data";
      default: return "stall";
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic check_value(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed", name);
      failed++;
    end
  endtask

  // returns 1 ns after the next clock edge that has clk_gate_i high
  task automatic wait_gated_edge();
    int   n;
    logic seen;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!clk_gate_i && n < GATE_WAIT);
    seen = clk_gate_i;  // value the dut sampled on this edge
    #1;
    if (!seen) abort_run("timeout: clk_gate_i never went high");
  endtask

  // one sie strobe, after 0..2 idle bit times of back-pressure
  task automatic send_strobe(input sie_out_t o, input sie_in_t i);
    int gaps;
    lcg_state = lcg_step(lcg_state);
    gaps = int'(lcg_state[17:16]) % 3;
    sie_out = '0;
    sie_in = '0;
    repeat (gaps) wait_gated_edge();
    sie_out = o;
    sie_in = i;
    wait_gated_edge();
    sie_out = '0;
    sie_in = '0;
  endtask

  task automatic send_setup(input logic [63:0] pkt);
    int k;
    send_strobe(out_tok(8'h00, 1'b0, 1'b1), '0);  // setup token
    for (k = 0; k < 8; k++) send_strobe(out_tok(pkt[63-8*k -: 8], 1'b1, 1'b0), '0);
    send_strobe(out_tok(8'h00, 1'b0, 1'b0), '0);  // eop
  endtask

  // data stage of a read, then the empty out status packet
  task automatic read_reply(output int cnt, output int sum, output logic [15:0] head);
    cnt = 0;
    sum = 0;
    head = '0;
    while (in_byte.valid && cnt < MAX_BYTES) begin
      if (cnt == 0) head[15:8] = in_byte.data;
      else if (cnt == 1) head[7:0] = in_byte.data;
      sum += int'(in_byte.data);
      cnt++;
      send_strobe('0, in_tok(1'b0, 1'b0));  // byte taken
    end
    if (in_byte.valid) begin
      abort_run("timeout: IN data never ended");
    end else begin
      send_strobe('0, in_tok(1'b0, 1'b1));  // ack after the last packet
      send_strobe(out_tok(8'h00, 1'b0, 1'b0), '0);
    end
  endtask

  task automatic run_status_stage(input int old_addr, input int old_cfg);
    send_strobe('0, in_tok(1'b1, 1'b0));  // host in token
    check_value("status zlp", int'(in_byte.valid & in_byte.zlp), 1);
    check_value("addr_o before status", int'(addr), old_addr);
    check_value("configured_o before status", int'(configured), old_cfg);
    send_strobe('0, in_tok(1'b0, 1'b1));  // zlp acked, request commits here
  endtask

  // one control transfer per vector line
  task automatic run_vectors(input int nvec);
    int t, k, base, outcome, exp_cnt, exp_sum, exp_addr, exp_cfg;
    int cnt, sum, errs_before, prev_addr, prev_cfg;
    logic [63:0] pkt;
    logic [15:0] head;
    prev_addr = 0;
    prev_cfg = 0;
    for (t = 0; t < nvec; t++) begin
      base = 1 + t * VEC_WORDS;
      for (k = 0; k < 8; k++) pkt[63-8*k -: 8] = vec_mem[base+k][7:0];
      outcome = int'(vec_mem[base+8]);
      exp_cnt = int'(vec_mem[base+9]);
      exp_sum = int'(vec_mem[base+10]);
      exp_addr = int'(vec_mem[base+11]);
      exp_cfg = int'(vec_mem[base+12]);
      errs_before = errors;
      send_setup(pkt);
      check_value("stall_o after setup", int'(stall), int'(outcome == 3));
      if (outcome == 1) begin
        read_reply(cnt, sum, head);
        check_value("byte count", cnt, exp_cnt);
        check_value("byte sum", sum, exp_sum);
        if (pkt[55:48] == 8'h06) begin  // descriptors open with length, type
          check_value("descriptor type", int'(head[7:0]), int'(pkt[39:32]));
          check_value("descriptor length", int'(head[15:8]),
                      (pkt[39:32] == 8'h01) ? `USB_DEV_DESCR_LEN : 9);
        end
      end else if (outcome == 2) begin
        check_value("in valid before status", int'(in_byte.valid), 0);
        run_status_stage(prev_addr, prev_cfg);
      end else begin
        check_value("in valid while stalled", int'(in_byte.valid), 0);
      end
      check_value("addr_o", int'(addr), exp_addr);
      check_value("configured_o", int'(configured), exp_cfg);
      prev_addr = exp_addr;
      prev_cfg = exp_cfg;
      report_test($sformatf("vector %0d %s", t, outcome_name(outcome)), errs_before);
    end
  endtask

  // setup with no payload stalls, bus reset then drops stall, address, configuration
  task automatic check_bus_reset();
    int errs_before;
    errs_before = errors;
    send_strobe(out_tok(8'h00, 1'b0, 1'b1), '0);  // setup token
    send_strobe(out_tok(8'h00, 1'b0, 1'b0), '0);  // eop, zero bytes
    check_value("stall_o after empty setup", int'(stall), 1);
    bus_reset_i = 1'b1;
    wait_gated_edge();
    bus_reset_i = 1'b0;
    check_value("addr_o after bus reset", int'(addr), 0);
    check_value("configured_o after bus reset", int'(configured), 0);
    check_value("usb_en_o after bus reset", int'(usb_en), 1);
    check_value("stall_o after bus reset", int'(stall), 0);
    report_test("bus reset when configured and stalled", errs_before);
  endtask

  initial begin
    int errs_before, prop_fails;
    rstn = 1'b0;
    bus_reset_i = 1'b0;
    clk_gate_i = 1'b0;
    gate_cnt = 2'd0;
    sie_out = '0;
    sie_in = '0;
    lcg_state = 32'h80ad;
    $readmemh("test/usb_ctrl_vectors.txt", vec_mem);
    repeat (2) @(posedge clk_i);
    #1 rstn = 1'b1;

    // powered until the first bus reset
    errs_before = errors;
    wait_gated_edge();
    wait_gated_edge();
    check_value("usb_en_o after rstn", int'(usb_en), 0);
    check_value("addr_o after rstn", int'(addr), 0);
    check_value("configured_o after rstn", int'(configured), 0);
    check_value("stall_o after rstn", int'(stall), 0);
    check_value("in valid after rstn", int'(in_byte.valid), 0);
    bus_reset_i = 1'b1;
    wait_gated_edge();
    bus_reset_i = 1'b0;
    check_value("usb_en_o after bus reset", int'(usb_en), 1);
    report_test("power-up and first bus reset", errs_before);

    if ($isunknown(vec_mem[0])) begin
      abort_run("vector file could not be read");
    end else if (vec_mem[0] < 16'd1 || vec_mem[0] > 16'(MAX_VECS)) begin
      abort_run("vector count in the file is out of range");
    end else begin
      run_vectors(int'(vec_mem[0]));
      check_bus_reset();
      prop_fails = u_usb_ctrl_top.u_usb_ctrl_properties.fail_cnt;
      $display("tests %0d, failed %0d, failed checks %0d, failed properties %0d",
               tests, failed, errors, prop_fails);
      if (errors == 0 && prop_fails == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: test/usb_ctrl_vectors.txt
// columns: setup bytes 0..7, outcome (1 read, 2 no data, 3 stall),
// byte count, 16-bit byte sum, addr_o after, configured_o after
// first word is the number of vectors
000D
80 06 00 01 00 00 40 00  1 12 012F 00 0   // device descriptor, wLength 64
80 06 00 02 00 00 09 00  1 09 0103 00 0   // config descriptor, first 9 bytes
80 06 00 02 00 00 FF 00  1 43 0435 00 0   // full config descriptor
80 08 00 00 00 00 01 00  3 00 0000 00 0   // get configuration in default state
00 03 01 00 00 00 00 00  3 00 0000 00 0   // set feature, not handled
00 05 05 00 00 00 00 00  2 00 0000 05 0   // set address 5
80 00 00 00 00 00 02 00  1 02 0000 05 0   // get status
00 09 01 00 00 00 00 00  2 00 0000 05 1   // set configuration 1
80 08 00 00 00 00 01 00  1 01 0001 05 1   // get configuration
81 0A 00 00 00 00 01 00  3 00 0000 05 1   // get interface, not handled
00 09 00 00 00 00 00 00  2 00 0000 05 0   // set configuration 0
80 08 00 00 00 00 01 00  1 01 0000 05 0   // get configuration, unconfigured
00 09 01 00 00 00 00 00  2 00 0000 05 1   // configure again before bus reset

// File: src.f
+incdir+include
hdl/usb_ctrl_pkg.sv
hdl/setup_decoder.sv
hdl/ctrl_stage_fsm.sv
hdl/descr_in_source.sv
hdl/device_state.sv
hdl/usb_ctrl_top.sv
test/usb_ctrl_properties.sv
test/tb_usb_ctrl.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_usb_ctrl
FILELIST  = src.f
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
